// File: include/lsq_macros.svh
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// tag width, slot 0 stands for "operand ready"
`define SLB_NICK_W 4
`define SLB_SLOTS (1 << `SLB_NICK_W)

`define SLB_DATA_W 32
`define SLB_ADDR_W 32

// data cache model
`define DC_WORDS 256
// cycles from acceptance to done
`define DC_LATENCY 2

`endif

// File: source/lsq_pkg.sv
`include "lsq_macros.svh"

package lsq_pkg;

    typedef enum logic [3:0] {
        OP_NONE,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_e;

    typedef enum logic [1:0] {
        LEN_ONE,
        LEN_TWO,
        LEN_FOUR
    } mem_len_e;

    // one instruction from dispatch, nick 0 means the data field is final
    typedef struct packed {
        mem_op_e                op;
        logic [`SLB_DATA_W-1:0] imm;
        logic [`SLB_NICK_W-1:0] rd_nick;
        logic [`SLB_NICK_W-1:0] rs1_nick;
        logic [`SLB_DATA_W-1:0] rs1_data;
        logic [`SLB_NICK_W-1:0] rs2_nick;
        logic [`SLB_DATA_W-1:0] rs2_data;
    } dispatch_t;

    typedef struct packed {
        logic                   valid;
        logic [`SLB_NICK_W-1:0] nick;
        logic [`SLB_DATA_W-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic                   valid;
        logic                   store;
        logic [`SLB_NICK_W-1:0] nick;
        mem_len_e               len;
        logic                   sign;
        logic [`SLB_ADDR_W-1:0] addr;
        logic [`SLB_DATA_W-1:0] data;
    } dc_req_t;

    typedef struct packed {
        logic                   done;
        logic [`SLB_NICK_W-1:0] nick;
        logic [`SLB_DATA_W-1:0] data;
    } dc_resp_t;

endpackage

// File: source/slb_select.sv
`include "lsq_macros.svh"

module slb_select (
    input  logic [`SLB_SLOTS-1:0]  occupied,
    input  logic [`SLB_SLOTS-1:0]  store,
    input  logic [`SLB_SLOTS-1:0]  committed,
    input  logic [`SLB_SLOTS-1:0]  issued,
    input  logic [`SLB_SLOTS-1:0]  rs1_valid,
    input  logic [`SLB_SLOTS-1:0]  rs2_valid,
    input  lsq_pkg::mem_op_e       ops      [`SLB_SLOTS],
    input  logic [`SLB_DATA_W-1:0] imms     [`SLB_SLOTS],
    input  logic [`SLB_DATA_W-1:0] rs1_data [`SLB_SLOTS],
    input  logic [`SLB_DATA_W-1:0] rs2_data [`SLB_SLOTS],
    output lsq_pkg::dc_req_t       req
);
    import lsq_pkg::*;

    localparam int SLOTS = `SLB_SLOTS;

    logic [SLOTS-1:0]       st_cand;
    logic [SLOTS-1:0]       ld_cand;
    logic [`SLB_NICK_W-1:0] st_pick;
    logic [`SLB_NICK_W-1:0] ld_pick;
    logic [`SLB_NICK_W-1:0] pick;

    // slot 0 is never occupied, so it never shows up here
    assign st_cand = occupied & store & committed & rs1_valid & rs2_valid;
    assign ld_cand = occupied & ~store & ~issued & rs1_valid;

    always_comb begin
        // lowest committed store
        st_pick = '0;
        for (int i = SLOTS - 1; i > 0; i--) begin
            if (st_cand[i]) begin
                st_pick = `SLB_NICK_W'(i);
            end
        end
        // highest ready load
        ld_pick = '0;
        for (int i = 1; i < SLOTS; i++) begin
            if (ld_cand[i]) begin
                ld_pick = `SLB_NICK_W'(i);
            end
        end
        pick = (|st_cand) ? st_pick : ld_pick;
    end

    always_comb begin
        req       = '0;
        req.valid = |st_cand || |ld_cand;
        req.store = |st_cand;
        req.nick  = pick;
        req.addr  = `SLB_ADDR_W'(rs1_data[pick] + imms[pick]);
        req.data  = (|st_cand) ? rs2_data[pick] : '0;
        case (ops[pick])
            LB: begin
                req.len  = LEN_ONE;
                req.sign = 1'b1;
            end
            LBU, SB: begin
                req.len  = LEN_ONE;
                req.sign = 1'b0;
            end
            LH: begin
                req.len  = LEN_TWO;
                req.sign = 1'b1;
            end
            LHU, SH: begin
                req.len  = LEN_TWO;
                req.sign = 1'b0;
            end
            default: begin
                req.len  = LEN_FOUR;
                req.sign = 1'b0;
            end
        endcase
    end

endmodule

// File: source/slb.sv
`include "lsq_macros.svh"

module slb (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clr,
    input  logic                   dispatch_en,
    input  lsq_pkg::dispatch_t     dispatch,
    input  lsq_pkg::cdb_t          ex_cdb,
    input  logic                   store_commit,
    input  logic [`SLB_NICK_W-1:0] store_nick,
    input  logic                   dc_ready,
    input  lsq_pkg::dc_resp_t      dc_resp,
    output lsq_pkg::dc_req_t       dc_req,
    output lsq_pkg::cdb_t          slb_cdb,
    output logic                   full
);
    import lsq_pkg::*;

    localparam int SLOTS = `SLB_SLOTS;

    logic [SLOTS-1:0]       occupied;
    logic [SLOTS-1:0]       store;
    logic [SLOTS-1:0]       committed;
    logic [SLOTS-1:0]       issued;
    logic [SLOTS-1:0]       rs1_valid;
    logic [SLOTS-1:0]       rs2_valid;

    mem_op_e                ops      [SLOTS];
    logic [`SLB_DATA_W-1:0] imms     [SLOTS];
    logic [`SLB_NICK_W-1:0] rs1_nick [SLOTS];
    logic [`SLB_NICK_W-1:0] rs2_nick [SLOTS];
    logic [`SLB_DATA_W-1:0] rs1_data [SLOTS];
    logic [`SLB_DATA_W-1:0] rs2_data [SLOTS];

    logic [SLOTS-1:0]       hit1;
    logic [SLOTS-1:0]       hit2;
    logic [SLOTS-1:0]       wake1;
    logic [SLOTS-1:0]       wake2;
    logic [`SLB_DATA_W-1:0] wake1_data [SLOTS];
    logic [`SLB_DATA_W-1:0] wake2_data [SLOTS];

    logic                   dp_store;
    logic                   dp_go;
    logic [`SLB_NICK_W-1:0] dp_idx;
    logic                   dp1_hit;
    logic                   dp2_hit;
    logic [`SLB_DATA_W-1:0] dp1_fwd;
    logic [`SLB_DATA_W-1:0] dp2_fwd;

    dc_req_t                sel_req;
    logic                   issue_ok;
    logic                   accept;
    logic                   resp_hit;

    // {hit, data} from whichever broadcast carries this nick
    function automatic logic [`SLB_DATA_W:0] snoop(input logic [`SLB_NICK_W-1:0] nick,
                                                   input cdb_t ex, input cdb_t own);
        logic [`SLB_DATA_W:0] res;
        res = '0;
        if (own.valid && own.nick == nick) begin
            res = {1'b1, own.data};
        end
        if (ex.valid && ex.nick == nick) begin
            res = {1'b1, ex.data};
        end
        if (nick == '0) begin
            res = '0;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            {hit1[i], wake1_data[i]} = snoop(rs1_nick[i], ex_cdb, slb_cdb);
            {hit2[i], wake2_data[i]} = snoop(rs2_nick[i], ex_cdb, slb_cdb);
        end
    end

    assign wake1 = hit1 & occupied & ~rs1_valid;
    assign wake2 = hit2 & occupied & ~rs2_valid;

    // operands broadcast in the dispatch cycle are caught here
    assign {dp1_hit, dp1_fwd} = snoop(dispatch.rs1_nick, ex_cdb, slb_cdb);
    assign {dp2_hit, dp2_fwd} = snoop(dispatch.rs2_nick, ex_cdb, slb_cdb);

    assign dp_store = dispatch.op inside {SB, SH, SW};
    assign dp_go    = dispatch_en && (dispatch.op inside {LB, LH, LW, LBU, LHU, SB, SH, SW});
    assign dp_idx   = dispatch.rd_nick;

    assign issue_ok = sel_req.valid && dc_ready && !dc_req.valid && !clr;
    assign accept   = dc_req.valid && dc_ready;
    assign resp_hit = dc_resp.done && occupied[dc_resp.nick]
                   && issued[dc_resp.nick] && !store[dc_resp.nick];
    assign full     = &occupied[SLOTS-1:1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied  <= '0;
            store     <= '0;
            committed <= '0;
            issued    <= '0;
            rs1_valid <= '0;
            rs2_valid <= '0;
        end else if (clr) begin
            occupied  <= '0;
            committed <= '0;
            issued    <= '0;
        end else begin
            rs1_valid <= rs1_valid | wake1;
            rs2_valid <= rs2_valid | wake2;
            // commit may come before the operands, the bit waits for them
            if (store_commit && occupied[store_nick] && store[store_nick]) begin
                committed[store_nick] <= 1'b1;
            end
            if (accept) begin
                if (dc_req.store) begin
                    occupied[dc_req.nick] <= 1'b0;
                end else begin
                    issued[dc_req.nick] <= 1'b1;
                end
            end
            if (resp_hit) begin
                occupied[dc_resp.nick] <= 1'b0;
            end
            if (dp_go) begin
                occupied[dp_idx]  <= 1'b1;
                store[dp_idx]     <= dp_store;
                committed[dp_idx] <= 1'b0;
                issued[dp_idx]    <= 1'b0;
                rs1_valid[dp_idx] <= dispatch.rs1_nick == '0 || dp1_hit;
                // loads have no second operand
                rs2_valid[dp_idx] <= !dp_store || dispatch.rs2_nick == '0 || dp2_hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOTS; i++) begin
            if (wake1[i]) begin
                rs1_data[i] <= wake1_data[i];
            end
            if (wake2[i]) begin
                rs2_data[i] <= wake2_data[i];
            end
        end
        if (dp_go) begin
            ops[dp_idx]      <= dispatch.op;
            imms[dp_idx]     <= dispatch.imm;
            rs1_nick[dp_idx] <= dispatch.rs1_nick;
            rs2_nick[dp_idx] <= dispatch.rs2_nick;
            rs1_data[dp_idx] <= dp1_hit ? dp1_fwd : dispatch.rs1_data;
            rs2_data[dp_idx] <= dp2_hit ? dp2_fwd : dispatch.rs2_data;
        end
    end

    slb_select select_i (
        .occupied  (occupied),
        .store     (store),
        .committed (committed),
        .issued    (issued),
        .rs1_valid (rs1_valid),
        .rs2_valid (rs2_valid),
        .ops       (ops),
        .imms      (imms),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .req       (sel_req)
    );

    // registered request, one in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_req <= '0;
        end else begin
            dc_req       <= sel_req;
            dc_req.valid <= issue_ok;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slb_cdb <= '0;
        end else begin
            slb_cdb.valid <= resp_hit && !clr;
            slb_cdb.nick  <= dc_resp.nick;
            slb_cdb.data  <= dc_resp.data;
        end
    end

    a_dp_free_slot: assert property (@(posedge clk) disable iff (!rst_n)
        dp_go |-> dp_idx != '0 && !occupied[dp_idx]);

    a_dp_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        dp_go |-> !full);

    // stale done after a flush is fine, anything else must match an issued load
    a_done_owner: assert property (@(posedge clk) disable iff (!rst_n)
        dc_resp.done |-> !occupied[dc_resp.nick]
                      || (issued[dc_resp.nick] && !store[dc_resp.nick]));

endmodule

// File: source/dcache_model.sv
`include "lsq_macros.svh"

module dcache_model (
    input  logic              clk,
    input  logic              rst_n,
    input  lsq_pkg::dc_req_t  req,
    output logic              ready,
    output lsq_pkg::dc_resp_t resp
);
    import lsq_pkg::*;

    localparam int IDX_W = $clog2(`DC_WORDS);
    localparam int CNT_W = $clog2(`DC_LATENCY + 1);

    logic [`SLB_DATA_W-1:0] mem [`DC_WORDS];
    logic                   busy;
    logic [CNT_W-1:0]       cnt;
    logic                   accept;
    logic [IDX_W-1:0]       idx;
    logic [1:0]             off;
    logic [3:0]             lane_en;
    logic [`SLB_DATA_W-1:0] wdata;
    logic [`SLB_DATA_W-1:0] shifted;
    logic [`SLB_DATA_W-1:0] rdata;

    assign ready   = ~busy;
    assign accept  = req.valid & ready;
    assign idx     = req.addr[IDX_W+1:2];
    assign off     = req.addr[1:0];
    assign shifted = mem[idx] >> {off, 3'b000};

    // lane enables and replicated store data, extended load data
    always_comb begin
        case (req.len)
            LEN_ONE: begin
                lane_en = 4'b0001 << off;
                wdata   = {4{req.data[7:0]}};
                rdata   = {{24{req.sign & shifted[7]}}, shifted[7:0]};
            end
            LEN_TWO: begin
                lane_en = 4'b0011 << off;
                wdata   = {2{req.data[15:0]}};
                rdata   = {{16{req.sign & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                lane_en = 4'b1111;
                wdata   = req.data;
                rdata   = shifted;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `DC_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (accept && req.store) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // load countdown, ready stays low until done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            resp <= '0;
        end else begin
            resp.done <= 1'b0;
            if (accept && !req.store) begin
                busy      <= 1'b1;
                cnt       <= CNT_W'(`DC_LATENCY - 1);
                resp.nick <= req.nick;
                resp.data <= rdata;
            end else if (busy) begin
                if (cnt == '0) begin
                    busy      <= 1'b0;
                    resp.done <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> (req.len == LEN_ONE)
                   || (req.len == LEN_TWO && !req.addr[0])
                   || (req.len == LEN_FOUR && req.addr[1:0] == 2'b00));

    // the buffer must hold off while a load is in flight
    a_req_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> ready);

endmodule

// File: source/lsu_top.sv
`include "lsq_macros.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clr,
    input  logic                   dispatch_en,
    input  lsq_pkg::dispatch_t     dispatch,
    input  lsq_pkg::cdb_t          ex_cdb,
    input  logic                   store_commit,
    input  logic [`SLB_NICK_W-1:0] store_nick,
    output lsq_pkg::cdb_t          slb_cdb,
    output logic                   full
);
    import lsq_pkg::*;

    dc_req_t  dc_req;
    dc_resp_t dc_resp;
    logic     dc_ready;

    slb slb_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clr          (clr),
        .dispatch_en  (dispatch_en),
        .dispatch     (dispatch),
        .ex_cdb       (ex_cdb),
        .store_commit (store_commit),
        .store_nick   (store_nick),
        .dc_ready     (dc_ready),
        .dc_resp      (dc_resp),
        .dc_req       (dc_req),
        .slb_cdb      (slb_cdb),
        .full         (full)
    );

    dcache_model dcache_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (dc_req),
        .ready (dc_ready),
        .resp  (dc_resp)
    );

endmodule

// File: verif/tb_lsu.sv
`include "lsq_macros.svh"

module tb_lsu;
    import lsq_pkg::*;

    typedef logic [`SLB_NICK_W-1:0] nick_t;

    localparam int SLOTS      = `SLB_SLOTS;
    localparam int IDX_W      = $clog2(`DC_WORDS);
    localparam int MAX_CYCLES = 5000;
    localparam int RANDOM_OPS = 150;

    logic      clk;
    logic      rst_n;
    logic      clr;
    logic      dispatch_en;
    dispatch_t dispatch;
    cdb_t      ex_cdb;
    logic      store_commit;
    nick_t     store_nick;
    cdb_t      slb_cdb;
    logic      full;

    logic [31:0] ref_mem  [`DC_WORDS];
    logic [31:0] exp_val  [SLOTS];
    string       exp_name [SLOTS];
    int          want_cnt [SLOTS];
    int          got_cnt  [SLOTS];
    int          errors  = 0;
    int          results = 0;
    int          cycles  = 0;
    nick_t       next_nick = nick_t'(1);

    lsu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clr          (clr),
        .dispatch_en  (dispatch_en),
        .dispatch     (dispatch),
        .ex_cdb       (ex_cdb),
        .store_commit (store_commit),
        .store_nick   (store_nick),
        .slb_cdb      (slb_cdb),
        .full         (full)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default: return 4;
        endcase
    endfunction

    // expected load value from the mirror memory
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] addr);
        logic [31:0] word;
        word = ref_mem[addr[IDX_W+1:2]] >> (8 * addr[1:0]);
        case (op)
            LB: return {{24{word[7]}}, word[7:0]};
            LBU: return {24'h0, word[7:0]};
            LH: return {{16{word[15]}}, word[15:0]};
            LHU: return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic mem_op_e random_op(input bit is_store);
        int k;
        k = $urandom_range(0, is_store ? 2 : 4);
        if (is_store) begin
            return (k == 0) ? SB : (k == 1) ? SH : SW;
        end
        return (k == 0) ? LB : (k == 1) ? LBU : (k == 2) ? LH : (k == 3) ? LHU : LW;
    endfunction

    // producers are taken from recently finished nicks
    function automatic nick_t prev_nick(input nick_t n);
        return (n == nick_t'(1)) ? nick_t'(SLOTS - 1) : nick_t'(n - 1);
    endfunction

    task automatic write_ref(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        int idx;
        int off;
        idx = int'(addr[IDX_W+1:2]);
        off = int'(addr[1:0]);
        for (int b = 0; b < op_bytes(op); b++) begin
            ref_mem[idx][8*(off+b) +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic take_nick(output nick_t n);
        n = next_nick;
        next_nick = (next_nick == nick_t'(SLOTS - 1)) ? nick_t'(1) : nick_t'(next_nick + 1);
    endtask

    // one clock edge with all strobes dropped
    task automatic step();
        @(posedge clk);
        dispatch_en  <= 1'b0;
        ex_cdb       <= '0;
        store_commit <= 1'b0;
        clr          <= 1'b0;
    endtask

    task automatic idle_cycles(input int k);
        repeat (k) step();
    endtask

    task automatic do_dispatch(input nick_t n, input mem_op_e op, input logic [31:0] imm,
                               input nick_t rs1_nick, input logic [31:0] rs1_data,
                               input nick_t rs2_nick, input logic [31:0] rs2_data);
        dispatch_t d;
        d.op       = op;
        d.imm      = imm;
        d.rd_nick  = n;
        d.rs1_nick = rs1_nick;
        d.rs1_data = rs1_data;
        d.rs2_nick = rs2_nick;
        d.rs2_data = rs2_data;
        step();
        dispatch_en <= 1'b1;
        dispatch    <= d;
    endtask

    task automatic do_broadcast(input nick_t n, input logic [31:0] data);
        step();
        ex_cdb.valid <= 1'b1;
        ex_cdb.nick  <= n;
        ex_cdb.data  <= data;
    endtask

    task automatic do_commit(input nick_t n, input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
        step();
        store_commit <= 1'b1;
        store_nick   <= n;
        write_ref(op, addr, data);
    endtask

    task automatic expect_load(input nick_t n, input logic [31:0] value, input string name);
        exp_name[n] = name;
        exp_val[n]  <= value;
        want_cnt[n] <= want_cnt[n] + 1;
    endtask

    task automatic wait_result(input nick_t n);
        @(negedge clk);
        while (want_cnt[n] != got_cnt[n]) begin
            @(negedge clk);
        end
    endtask

    task automatic store_op(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data,
                            input bit late_base, input bit late_data, input bit commit_first);
        nick_t       n;
        nick_t       p1;
        nick_t       p2;
        logic [31:0] imm;
        take_nick(n);
        p1  = prev_nick(n);
        p2  = prev_nick(p1);
        imm = 32'($urandom_range(0, 255));
        do_dispatch(n, op, imm, late_base ? p1 : '0, late_base ? $urandom : addr - imm,
                    late_data ? p2 : '0, late_data ? $urandom : data);
        if (commit_first) begin
            do_commit(n, op, addr, data);
        end
        if (late_base) begin
            do_broadcast(p1, addr - imm);
        end
        if (late_data) begin
            do_broadcast(p2, data);
        end
        if (!commit_first) begin
            do_commit(n, op, addr, data);
        end
        step();
    endtask

    task automatic load_op(input mem_op_e op, input logic [31:0] addr, input bit late,
                           input string name);
        nick_t       n;
        logic [31:0] imm;
        take_nick(n);
        imm = 32'($urandom_range(0, 255));
        do_dispatch(n, op, imm, late ? prev_nick(n) : '0, late ? $urandom : addr - imm, '0, 0);
        expect_load(n, ref_load(op, addr), name);
        if (late) begin
            idle_cycles($urandom_range(0, 3));
            do_broadcast(prev_nick(n), addr - imm);
        end
        step();
        wait_result(n);
    endtask

    task automatic report_and_stop(input bit hung);
        $display("errors: %0d, load results: %0d, cycles: %0d", errors, results, cycles);
        if (errors == 0 && !hung) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // compare every load result against the queued value
    always @(posedge clk) begin
        if (rst_n && slb_cdb.valid) begin
            results++;
            if (want_cnt[slb_cdb.nick] == got_cnt[slb_cdb.nick]) begin
                errors++;
                $display("unexpected load result on nick %0d, data %h",
                         slb_cdb.nick, slb_cdb.data);
            end else begin
                if (slb_cdb.data !== exp_val[slb_cdb.nick]) begin
                    errors++;
                    $display("FAILED %s: nick %0d expected %h actual %h", exp_name[slb_cdb.nick],
                             slb_cdb.nick, exp_val[slb_cdb.nick], slb_cdb.data);
                end
                got_cnt[slb_cdb.nick] <= got_cnt[slb_cdb.nick] + 1;
            end
        end
    end

    // about 200 ops at up to 12 cycles with margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run hung, no finish after %0d cycles", MAX_CYCLES);
            report_and_stop(1'b1);
        end
    end

    initial begin
        nick_t   na;
        nick_t   nb;
        nick_t   ns;
        int      seen;
        bit      is_store;
        mem_op_e op;
        logic [31:0] addr;
        void'($urandom(496));
        rst_n        = 1'b0;
        clr          = 1'b0;
        dispatch_en  = 1'b0;
        dispatch     = '0;
        ex_cdb       = '0;
        store_commit = 1'b0;
        store_nick   = '0;
        for (int w = 0; w < `DC_WORDS; w++) begin
            ref_mem[w] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(2);

        // widths and extension
        store_op(SW, 32'h40, 32'h8765_f0a1, 0, 0, 0);
        store_op(SH, 32'h46, 32'h0000_9abc, 0, 0, 0);
        store_op(SB, 32'h45, 32'h0000_00c3, 0, 0, 0);
        store_op(SB, 32'h47, 32'h0000_007e, 0, 0, 0);
        for (int a = 0; a < 8; a++) begin
            load_op(LB, 32'(32'h40 + a), 0, "widths");
            load_op(LBU, 32'(32'h40 + a), 0, "widths");
            if (a % 2 == 0) begin
                load_op(LH, 32'(32'h40 + a), 0, "widths");
                load_op(LHU, 32'(32'h40 + a), 0, "widths");
            end
            if (a % 4 == 0) begin
                load_op(LW, 32'(32'h40 + a), 0, "widths");
            end
        end

        // base from the execute unit arrives late
        take_nick(na);
        do_dispatch(na, LW, 32'd8, prev_nick(na), 32'hdead_beef, '0, 0);
        expect_load(na, ref_load(LW, 32'h44), "ex_wakeup");
        seen = got_cnt[na];
        idle_cycles(10);
        @(negedge clk);
        if (got_cnt[na] != seen) begin
            errors++;
            $display("ex_wakeup: load returned before its base was broadcast");
        end
        do_broadcast(prev_nick(na), 32'h3c);
        step();
        wait_result(na);

        // second load takes its base from the first one's result
        store_op(SW, 32'h80, 32'h0000_0100, 0, 0, 0);
        store_op(SW, 32'h104, 32'hcafe_8001, 0, 0, 0);
        take_nick(na);
        take_nick(nb);
        do_dispatch(na, LW, 32'd0, '0, 32'h80, '0, 0);
        expect_load(na, ref_load(LW, 32'h80), "load_to_load");
        do_dispatch(nb, LH, 32'd6, na, 32'h1234_5678, '0, 0);
        expect_load(nb, ref_load(LH, ref_load(LW, 32'h80) + 32'd6), "load_to_load");
        step();
        wait_result(na);
        wait_result(nb);

        // a ready but uncommitted store stays out of memory
        take_nick(ns);
        do_dispatch(ns, SW, 32'd0, '0, 32'h200, prev_nick(ns), 32'h0);
        do_broadcast(prev_nick(ns), 32'h5a5a_c3c3);
        load_op(LW, 32'h200, 0, "store_commit_old");
        do_commit(ns, SW, 32'h200, 32'h5a5a_c3c3);
        step();
        load_op(LW, 32'h200, 0, "store_commit_new");

        // fill every slot and flush
        for (int n = 1; n < SLOTS; n++) begin
            do_dispatch(nick_t'(n), LW, 32'd0, nick_t'(n % (SLOTS - 1) + 1), 0, '0, 0);
        end
        step();
        @(negedge clk);
        if (!full) begin
            errors++;
            $display("full is low with all slots occupied");
        end
        step();
        clr <= 1'b1;
        step();
        @(negedge clk);
        if (full) begin
            errors++;
            $display("full is still high after the flush");
        end
        for (int n = 1; n < SLOTS; n++) begin
            do_broadcast(nick_t'(n), 32'($urandom_range(0, 63)) * 4);
        end
        idle_cycles(20);
        next_nick = nick_t'(1);

        // random mix with stores committed before later loads
        for (int i = 0; i < RANDOM_OPS; i++) begin
            is_store = ($urandom_range(0, 2) == 0);
            op       = random_op(is_store);
            addr     = 32'($urandom_range(0, 63)) * 4;
            addr     = addr + 32'($urandom_range(0, 3) & (4 - op_bytes(op)));
            if (is_store) begin
                store_op(op, addr, $urandom, $urandom_range(0, 1) == 1,
                         $urandom_range(0, 1) == 1, $urandom_range(0, 1) == 1);
            end else begin
                load_op(op, addr, $urandom_range(0, 1) == 1, "random");
            end
        end

        idle_cycles(20);
        @(negedge clk);
        for (int n = 1; n < SLOTS; n++) begin
            if (want_cnt[n] != got_cnt[n]) begin
                errors++;
                $display("no result arrived for nick %0d in %s", n, exp_name[n]);
            end
        end
        report_and_stop(1'b0);
    end

endmodule

// File: all.f
+incdir+include
source/lsq_pkg.sv
source/slb_select.sv
source/slb.sv
source/dcache_model.sv
source/lsu_top.sv
verif/tb_lsu.sv

// File: run.sh
#!/bin/sh
# compile and run the load/store buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_lsu \
    --Mdir obj_dir -o sim_lsu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_lsu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1
